//--- source/rvseed_consts.svh
`ifndef RVSEED_CONSTS_SVH
`define RVSEED_CONSTS_SVH

// datapath widths fixed by RV32I
`define CPU_WIDTH          32
`define REG_ADDR_WIDTH     5
`define OPCODE_WIDTH       7
`define FUNCT3_WIDTH       3
`define FUNCT7_WIDTH       7

// major opcodes
`define INST_TYPE_R        7'b0110011
`define INST_TYPE_I        7'b0010011
`define INST_TYPE_B        7'b1100011
`define INST_JAL           7'b1101111
`define INST_JALR          7'b1100111
`define INST_LUI           7'b0110111
`define INST_AUIPC         7'b0010111
`define INST_SYSTEM        7'b1110011

// funct3 / funct7 codes
`define INST_ADD_SUB       3'b000
`define INST_ADDI          3'b000
`define INST_BNE           3'b001
`define INST_JALR_F3       3'b000
`define FUNCT7_INST_A      7'b0000000    // add
`define FUNCT7_INST_B      7'b0100000    // sub

// alu operation
`define ALU_OP_WIDTH       2
`define ALU_ADD            2'd0
`define ALU_SUB            2'd1
`define ALU_JALR           2'd2

// immediate format
`define IMM_GEN_OP_WIDTH   2
`define IMM_GEN_I          2'd0
`define IMM_GEN_B          2'd1
`define IMM_GEN_U          2'd2
`define IMM_GEN_J          2'd3

// writeback / operand source
`define ALU_SRC_WIDTH      2
`define ALU_SRC_REG        2'd0
`define ALU_SRC_IMM        2'd1
`define ALU_SRC_FOUR_PC    2'd2
`define ALU_SRC_IMM_PC     2'd3

`define EBREAK_WORD        32'h0010_0073
`define RESET_PC           32'h0000_0000

`endif

//--- source/rvseed_pkg.sv
`default_nettype none

`include "rvseed_consts.svh"

package rvseed_pkg;

    typedef struct packed {
        logic [`FUNCT7_WIDTH-1:0]   funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`FUNCT3_WIDTH-1:0]   funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`FUNCT3_WIDTH-1:0]   funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic                       imm12;      // sign bit
        logic [5:0]                 imm10_5;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`FUNCT3_WIDTH-1:0]   funct3;
        logic [3:0]                 imm4_1;
        logic                       imm11;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]                imm20;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                       imm20;      // sign bit
        logic [9:0]                 imm10_1;
        logic                       imm11;
        logic [7:0]                 imm19_12;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } j_fmt_t;

    // one word, five views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef struct packed {
        logic                          branch;
        logic                          jump;
        logic                          reg_wen;
        logic [`REG_ADDR_WIDTH-1:0]    reg_waddr;
        logic [`REG_ADDR_WIDTH-1:0]    reg1_raddr;
        logic [`REG_ADDR_WIDTH-1:0]    reg2_raddr;
        logic [`IMM_GEN_OP_WIDTH-1:0]  imm_gen_op;
        logic [`ALU_OP_WIDTH-1:0]      alu_op;
        logic [`ALU_SRC_WIDTH-1:0]     alu_src_sel;
    } ctrl_t;

    // fetch to execute register
    typedef struct packed {
        logic                   valid;
        logic [`CPU_WIDTH-1:0]  pc;
        inst_t                  inst;
    } fetch_t;

endpackage

`default_nettype wire

//--- source/ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module ctrl import rvseed_pkg::*; (
    input  inst_t inst,         // instruction in execute
    output ctrl_t c,            // decoded control
    output logic  illegal,      // no supported encoding
    output logic  is_ebreak     // exact ebreak word
);

    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`FUNCT3_WIDTH-1:0]   funct3;
    logic [`FUNCT7_WIDTH-1:0]   funct7;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;
    assign rd     = inst.r_fmt.rd;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;

    assign is_ebreak = (inst == `EBREAK_WORD);

    always_comb begin
        c.branch      = 1'b0;
        c.jump        = 1'b0;
        c.reg_wen     = 1'b0;
        c.reg_waddr   = '0;
        c.reg1_raddr  = '0;
        c.reg2_raddr  = '0;
        c.imm_gen_op  = `IMM_GEN_I;
        c.alu_op      = `ALU_ADD;
        c.alu_src_sel = `ALU_SRC_REG;
        illegal       = 1'b0;
        case (opcode)
            `INST_TYPE_R: begin
                c.reg_wen    = 1'b1;
                c.reg1_raddr = rs1;
                c.reg2_raddr = rs2;
                c.reg_waddr  = rd;
                if (funct3 != `INST_ADD_SUB)
                    illegal = 1'b1;
                else if (funct7 == `FUNCT7_INST_A)
                    c.alu_op = `ALU_ADD;
                else if (funct7 == `FUNCT7_INST_B)
                    c.alu_op = `ALU_SUB;
                else
                    illegal = 1'b1;
            end
            `INST_TYPE_I: begin
                c.reg_wen     = 1'b1;
                c.reg1_raddr  = rs1;
                c.reg_waddr   = rd;
                c.alu_src_sel = `ALU_SRC_IMM;
                if (funct3 != `INST_ADDI)
                    illegal = 1'b1;
            end
            `INST_TYPE_B: begin
                c.reg1_raddr = rs1;
                c.reg2_raddr = rs2;
                c.imm_gen_op = `IMM_GEN_B;
                c.alu_op     = `ALU_SUB;   // nonzero difference means ne
                if (funct3 == `INST_BNE)
                    c.branch = 1'b1;
                else
                    illegal = 1'b1;
            end
            `INST_JAL: begin
                c.jump        = 1'b1;
                c.reg_wen     = 1'b1;
                c.reg_waddr   = rd;
                c.imm_gen_op  = `IMM_GEN_J;
                c.alu_src_sel = `ALU_SRC_FOUR_PC;  // link pc+4
            end
            `INST_JALR: begin
                c.jump        = 1'b1;
                c.reg_wen     = 1'b1;
                c.reg1_raddr  = rs1;               // target base
                c.reg_waddr   = rd;
                c.alu_op      = `ALU_JALR;
                c.alu_src_sel = `ALU_SRC_FOUR_PC;
                if (funct3 != `INST_JALR_F3)
                    illegal = 1'b1;
            end
            `INST_LUI: begin
                c.reg_wen     = 1'b1;
                c.reg_waddr   = rd;
                c.imm_gen_op  = `IMM_GEN_U;
                c.alu_src_sel = `ALU_SRC_IMM;      // x0 + imm
            end
            `INST_AUIPC: begin
                c.reg_wen     = 1'b1;
                c.reg_waddr   = rd;
                c.imm_gen_op  = `IMM_GEN_U;
                c.alu_src_sel = `ALU_SRC_IMM_PC;   // pc + imm
            end
            `INST_SYSTEM: begin
                if (!is_ebreak)
                    illegal = 1'b1;                // only ebreak handled
            end
            default: illegal = 1'b1;
        endcase
        // unknown words must not touch state or the pc
        if (illegal) begin
            c.reg_wen = 1'b0;
            c.branch  = 1'b0;
            c.jump    = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module imm_gen import rvseed_pkg::*; (
    input  inst_t                         inst,
    input  logic [`IMM_GEN_OP_WIDTH-1:0]  imm_gen_op,
    output logic [`CPU_WIDTH-1:0]         imm
);

    logic [`CPU_WIDTH-1:0] imm_i;
    logic [`CPU_WIDTH-1:0] imm_b;
    logic [`CPU_WIDTH-1:0] imm_u;
    logic [`CPU_WIDTH-1:0] imm_j;

    assign imm_i = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

    assign imm_b = {{20{inst.b_fmt.imm12}},
                    inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5,
                    inst.b_fmt.imm4_1,
                    1'b0};                    // halfword offset

    assign imm_u = {inst.u_fmt.imm20, 12'b0};

    assign imm_j = {{12{inst.j_fmt.imm20}},
                    inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11,
                    inst.j_fmt.imm10_1,
                    1'b0};

    always_comb begin
        case (imm_gen_op)
            `IMM_GEN_I: imm = imm_i;
            `IMM_GEN_B: imm = imm_b;
            `IMM_GEN_U: imm = imm_u;
            default:    imm = imm_j;
        endcase
    end

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module regfile (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wen,
    input  logic [`REG_ADDR_WIDTH-1:0]   waddr,
    input  logic [`CPU_WIDTH-1:0]        wdata,
    input  logic [`REG_ADDR_WIDTH-1:0]   raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0]   raddr2,
    output logic [`CPU_WIDTH-1:0]        rdata1,
    output logic [`CPU_WIDTH-1:0]        rdata2
);

    logic [`CPU_WIDTH-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // plain reads, no write bypass needed in two stages
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module exec_unit import rvseed_pkg::*; (
    input  ctrl_t                  c,
    input  logic [`CPU_WIDTH-1:0]  pc,
    input  logic [`CPU_WIDTH-1:0]  imm,
    input  logic [`CPU_WIDTH-1:0]  rdata1,
    input  logic [`CPU_WIDTH-1:0]  rdata2,
    output logic [`CPU_WIDTH-1:0]  wb_data,
    output logic                   redirect,
    output logic [`CPU_WIDTH-1:0]  redirect_pc
);

    logic [`CPU_WIDTH-1:0] op_b;
    logic [`CPU_WIDTH-1:0] alu_sum;
    logic [`CPU_WIDTH-1:0] alu_diff;
    logic [`CPU_WIDTH-1:0] alu_res;
    logic [`CPU_WIDTH-1:0] pc_imm;
    logic [`CPU_WIDTH-1:0] pc_four;

    assign op_b     = (c.alu_src_sel == `ALU_SRC_REG) ? rdata2 : imm;
    assign alu_sum  = rdata1 + op_b;
    assign alu_diff = rdata1 - op_b;
    assign pc_imm   = pc + imm;        // auipc, branch and jal target
    assign pc_four  = pc + 32'd4;      // link address

    always_comb begin
        case (c.alu_op)
            `ALU_SUB:  alu_res = alu_diff;
            `ALU_JALR: alu_res = {alu_sum[`CPU_WIDTH-1:1], 1'b0};
            default:   alu_res = alu_sum;
        endcase
    end

    always_comb begin
        case (c.alu_src_sel)
            `ALU_SRC_FOUR_PC: wb_data = pc_four;
            `ALU_SRC_IMM_PC:  wb_data = pc_imm;
            default:          wb_data = alu_res;
        endcase
    end

    assign redirect    = c.jump | (c.branch & (|alu_res));   // bne taken
    assign redirect_pc = (c.alu_op == `ALU_JALR) ? alu_res : pc_imm;

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module fetch_stage import rvseed_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`CPU_WIDTH-1:0]  inst_data,     // combinational imem data
    input  logic                   redirect,
    input  logic [`CPU_WIDTH-1:0]  redirect_pc,
    input  logic                   freeze,        // halt or illegal
    output logic [`CPU_WIDTH-1:0]  inst_addr,
    output fetch_t                 fet
);

    logic [`CPU_WIDTH-1:0] pc;
    logic                  fet_valid;
    logic [`CPU_WIDTH-1:0] fet_pc;
    inst_t                 fet_inst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= `RESET_PC;
            fet_valid <= 1'b0;
        end else if (!freeze) begin
            if (redirect) begin
                pc        <= redirect_pc;
                fet_valid <= 1'b0;          // flush the wrong-path word
            end else begin
                pc        <= pc + 32'd4;
                fet_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            fet_pc   <= pc;
            fet_inst <= inst_data;
        end
    end

    assign inst_addr = pc;

    assign fet.valid = fet_valid;
    assign fet.pc    = fet_pc;
    assign fet.inst  = fet_inst;

endmodule

`default_nettype wire

//--- source/rvseed_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module rvseed_core import rvseed_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`CPU_WIDTH-1:0]        inst_data,
    output logic [`CPU_WIDTH-1:0]        inst_addr,
    output logic                         retire_valid,
    output logic [`CPU_WIDTH-1:0]        retire_pc,
    output logic [`REG_ADDR_WIDTH-1:0]   retire_rd,
    output logic                         retire_wen,
    output logic [`CPU_WIDTH-1:0]        retire_data,
    output logic                         halt,
    output logic                         illegal
);

    fetch_t                 fet;
    ctrl_t                  c;
    logic                   dec_illegal;
    logic                   is_ebreak;
    logic [`CPU_WIDTH-1:0]  imm;
    logic [`CPU_WIDTH-1:0]  rdata1;
    logic [`CPU_WIDTH-1:0]  rdata2;
    logic [`CPU_WIDTH-1:0]  wb_data;
    logic                   ex_redirect;
    logic [`CPU_WIDTH-1:0]  redirect_pc;
    logic                   ex_valid;
    logic                   freeze;

    assign ex_valid = fet.valid & ~halt & ~illegal;   // nothing executes once stopped
    // stop the pc in the same edge the ebreak or bad word executes
    assign freeze   = halt | illegal | (ex_valid & (is_ebreak | dec_illegal));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt    <= 1'b0;
            illegal <= 1'b0;
        end else if (ex_valid) begin
            if (is_ebreak)
                halt <= 1'b1;
            if (dec_illegal)
                illegal <= 1'b1;
        end
    end

    fetch_stage u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_data   (inst_data),
        .redirect    (ex_valid & ex_redirect),
        .redirect_pc (redirect_pc),
        .freeze      (freeze),
        .inst_addr   (inst_addr),
        .fet         (fet)
    );

    ctrl u_ctrl (
        .inst      (fet.inst),
        .c         (c),
        .illegal   (dec_illegal),
        .is_ebreak (is_ebreak)
    );

    imm_gen u_imm_gen (
        .inst       (fet.inst),
        .imm_gen_op (c.imm_gen_op),
        .imm        (imm)
    );

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .wen    (ex_valid & c.reg_wen),
        .waddr  (c.reg_waddr),
        .wdata  (wb_data),
        .raddr1 (c.reg1_raddr),
        .raddr2 (c.reg2_raddr),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit u_exec (
        .c           (c),
        .pc          (fet.pc),
        .imm         (imm),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .wb_data     (wb_data),
        .redirect    (ex_redirect),
        .redirect_pc (redirect_pc)
    );

    assign retire_valid = ex_valid;
    assign retire_pc    = fet.pc;
    assign retire_rd    = c.reg_waddr;
    assign retire_wen   = ex_valid & c.reg_wen;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

//--- bench/rvseed_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module rvseed_props (
    input logic                        clk,
    input logic                        arst_n,
    input logic [`CPU_WIDTH-1:0]       inst_addr,
    input logic                        retire_valid,
    input logic                        retire_wen,
    input logic [`REG_ADDR_WIDTH-1:0]  retire_rd,
    input logic                        halt,
    input logic                        illegal,
    input logic [`REG_ADDR_WIDTH-1:0]  raddr1,
    input logic [`REG_ADDR_WIDTH-1:0]  raddr2,
    input logic [`CPU_WIDTH-1:0]       rdata1,
    input logic [`CPU_WIDTH-1:0]       rdata2
);

    a_reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> !retire_valid && !halt && !illegal)
        else $error("retire or stop flag high in the first cycle after reset");

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halt |=> halt)
        else $error("halt dropped without reset");

    // a write aimed at x0 must leave x0 reading as zero
    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (retire_wen && retire_rd == '0) |=>
            ((raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0)))
        else $error("x0 read back nonzero after a write to it");

    a_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        inst_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

endmodule

bind rvseed_core rvseed_props i_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_addr    (inst_addr),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_rd    (retire_rd),
    .halt         (halt),
    .illegal      (illegal),
    .raddr1       (c.reg1_raddr),
    .raddr2       (c.reg2_raddr),
    .rdata1       (rdata1),
    .rdata2       (rdata2)
);

`default_nettype wire

//--- bench/rvseed_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module rvseed_checker (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         retire_valid,
    input  logic [`CPU_WIDTH-1:0]        retire_pc,
    input  logic [`REG_ADDR_WIDTH-1:0]   retire_rd,
    input  logic                         retire_wen,
    input  logic [`CPU_WIDTH-1:0]        retire_data,
    input  logic                         halt,
    input  logic                         illegal,
    input  int                           a_len,
    input  int                           b_len,
    output int                           runs_done,
    output int                           err_cnt
);

    localparam int RETIRE_LIMIT = 20;   // covers a redirect bubble with margin
    localparam int RESET_LIMIT  = 50;
    localparam int QUIET_CYCLES = 10;

    int row_cnt;                        // rows and stop checks finished

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, inout bit ok);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %08h expected %08h", $time, name, got, exp);
            err_cnt++;
            ok = 1'b0;
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    task automatic wait_reset_level(input logic level, output bit ok);
        int cnt;
        cnt = 0;
        while (arst_n !== level && cnt < RESET_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        ok = (arst_n === level);
    endtask

    task automatic wait_retire(output bit ok);
        int cnt;
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < RETIRE_LIMIT) begin
            @(negedge clk);
            cnt++;
            if (retire_valid === 1'b1)
                ok = 1'b1;
        end
    endtask

    task automatic check_quiet(input int run);
        bit   ok;
        logic exp_halt;
        logic exp_ill;
        ok       = 1'b1;
        exp_halt = (run == 0);
        exp_ill  = (run == 1);
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            compare("retire_valid", {31'b0, retire_valid}, 32'd0, ok);
            compare("halt", {31'b0, halt}, {31'b0, exp_halt}, ok);
            compare("illegal", {31'b0, illegal}, {31'b0, exp_ill}, ok);
        end
        row_cnt++;
        $display("run %0d stop flag and %0d idle cycles %s", run, QUIET_CYCLES,
                 ok ? "ok" : "mismatch");
    endtask

    task automatic check_run(input int run, input int base, input int len);
        bit ok;
        bit alive;
        alive = 1'b1;
        for (int i = 0; i < len && alive; i++) begin
            if (rvseed_tb.tbl[base+i].retire) begin
                wait_retire(alive);
                if (!alive) begin
                    $display("timeout: row %0d of run %0d never retired", i, run);
                    err_cnt++;
                end else begin
                    ok = 1'b1;
                    compare("retire_pc", retire_pc, 32'(4 * i), ok);
                    compare("retire_wen", {31'b0, retire_wen},
                            {31'b0, rvseed_tb.tbl[base+i].wen}, ok);
                    if (rvseed_tb.tbl[base+i].wen) begin
                        compare("retire_rd", {27'b0, retire_rd},
                                {27'b0, rvseed_tb.tbl[base+i].rd}, ok);
                        compare("retire_data", retire_data, rvseed_tb.tbl[base+i].data, ok);
                    end
                    row_cnt++;
                    $display("run %0d row %0d pc %08h %s", run, i, retire_pc,
                             ok ? "ok" : "mismatch");
                end
            end else begin
                $display("run %0d row %0d skipped", run, i);   // wrong-path word
            end
        end
        if (alive)
            check_quiet(run);
    endtask

    initial begin
        bit ok;
        runs_done = 0;
        row_cnt   = 0;
        err_cnt   = 0;
        wait_reset_level(1'b1, ok);
        if (ok) begin
            check_run(0, 0, a_len);
        end else begin
            $display("reset was never released for the first run");
            err_cnt++;
        end
        runs_done = 1;
        wait_reset_level(1'b0, ok);
        if (ok)
            wait_reset_level(1'b1, ok);
        if (ok) begin
            check_run(1, a_len, b_len);
        end else begin
            $display("second reset pulse never came");
            err_cnt++;
        end
        runs_done = 2;
        $display("%0d checks done, %0d errors", row_cnt, err_cnt);
    end

endmodule

`default_nettype wire

//--- bench/rvseed_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_consts.svh"

module rvseed_tb;

    typedef struct packed {
        logic [`CPU_WIDTH-1:0]      word;
        logic                       retire;     // expected to show on the retire port
        logic                       wen;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`CPU_WIDTH-1:0]      data;
    } row_t;

    localparam int TBL_DEPTH  = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int RUN_LIMIT  = 200;            // cycles allowed per run

    logic                        clk;
    logic                        arst_n;
    logic [`CPU_WIDTH-1:0]       inst_addr;
    logic [`CPU_WIDTH-1:0]       inst_data;
    logic                        retire_valid;
    logic [`CPU_WIDTH-1:0]       retire_pc;
    logic [`REG_ADDR_WIDTH-1:0]  retire_rd;
    logic                        retire_wen;
    logic [`CPU_WIDTH-1:0]       retire_data;
    logic                        halt;
    logic                        illegal;

    logic [`CPU_WIDTH-1:0] imem [0:IMEM_DEPTH-1];
    row_t                  tbl  [0:TBL_DEPTH-1];
    int                    n_rows;
    int                    a_len;
    int                    b_len;
    int                    runs_done;
    int                    err_cnt;
    logic [31:0]           rng;
    logic                  checker_timeout;

    assign inst_data = imem[inst_addr[7:2]];    // combinational fetch

    rvseed_core i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_data    (inst_data),
        .inst_addr    (inst_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data),
        .halt         (halt),
        .illegal      (illegal)
    );

    rvseed_checker i_chk (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wen   (retire_wen),
        .retire_data  (retire_data),
        .halt         (halt),
        .illegal      (illegal),
        .a_len        (a_len),
        .b_len        (b_len),
        .runs_done    (runs_done),
        .err_cnt      (err_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, `INST_ADD_SUB, rd, `INST_TYPE_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, op};       // addi and jalr share funct3 0
    endfunction

    function automatic logic [31:0] enc_bne(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {off[12], off[10:5], rs2, rs1, `INST_BNE, off[4:1], off[11], `INST_TYPE_B};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `INST_JAL};
    endfunction

    task automatic add_row(input logic [31:0] w, input logic ret, input logic we,
                           input logic [4:0] rd, input logic [31:0] d);
        tbl[n_rows].word   = w;
        tbl[n_rows].retire = ret;
        tbl[n_rows].wen    = we;
        tbl[n_rows].rd     = rd;
        tbl[n_rows].data   = d;
        n_rows++;
    endtask

    task automatic build_table();
        logic [11:0] r1;
        logic [11:0] r2;
        logic [11:0] r3;
        logic [11:0] r4;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        rng = xorshift32(32'd7096);
        r1  = rng[11:0];
        rng = xorshift32(rng);
        r2  = rng[11:0];
        if (r2 == r1)
            r2 = r1 ^ 12'h001;                  // bne below must be taken
        rng = xorshift32(rng);
        r3  = rng[11:0];
        rng = xorshift32(rng);
        r4  = rng[11:0];
        x1  = sext12(r1);
        x2  = sext12(r2);
        x3  = x1 + x2;
        x4  = x1 - x2;
        // run A, row n at byte address 4*n
        add_row(enc_i(`INST_TYPE_I, r1, 5'd0, 5'd1), 1'b1, 1'b1, 5'd1, x1);
        add_row(enc_i(`INST_TYPE_I, r2, 5'd0, 5'd2), 1'b1, 1'b1, 5'd2, x2);
        add_row(enc_r(`FUNCT7_INST_A, 5'd2, 5'd1, 5'd3), 1'b1, 1'b1, 5'd3, x3);
        add_row(enc_r(`FUNCT7_INST_B, 5'd2, 5'd1, 5'd4), 1'b1, 1'b1, 5'd4, x4);
        add_row(enc_i(`INST_TYPE_I, 12'd5, 5'd1, 5'd0), 1'b1, 1'b1, 5'd0, x1 + 32'd5);
        add_row(enc_r(`FUNCT7_INST_A, 5'd3, 5'd0, 5'd5), 1'b1, 1'b1, 5'd5, x3);
        add_row(enc_u(`INST_LUI, 20'habcde, 5'd6), 1'b1, 1'b1, 5'd6, 32'habcd_e000);
        add_row(enc_u(`INST_AUIPC, 20'h12345, 5'd7), 1'b1, 1'b1, 5'd7, 32'h1234_5000 + 32'd28);
        add_row(enc_bne(13'd8, 5'd2, 5'd1), 1'b1, 1'b0, 5'd0, 32'd0);      // taken
        add_row(enc_i(`INST_TYPE_I, 12'd1, 5'd0, 5'd8), 1'b0, 1'b0, 5'd8, 32'd0);
        add_row(enc_bne(13'd8, 5'd3, 5'd3), 1'b1, 1'b0, 5'd0, 32'd0);      // not taken
        add_row(enc_i(`INST_TYPE_I, 12'd2, 5'd0, 5'd8), 1'b1, 1'b1, 5'd8, 32'd2);
        add_row(enc_jal(21'd12, 5'd9), 1'b1, 1'b1, 5'd9, 32'd52);
        add_row(enc_i(`INST_TYPE_I, 12'd3, 5'd0, 5'd10), 1'b0, 1'b0, 5'd10, 32'd0);
        add_row(enc_i(`INST_TYPE_I, 12'd4, 5'd0, 5'd10), 1'b0, 1'b0, 5'd10, 32'd0);
        add_row(enc_i(`INST_TYPE_I, 12'd77, 5'd0, 5'd11), 1'b1, 1'b1, 5'd11, 32'd77);
        add_row(enc_i(`INST_JALR, 12'd4, 5'd11, 5'd12), 1'b1, 1'b1, 5'd12, 32'd68);
        add_row(enc_i(`INST_TYPE_I, 12'd9, 5'd0, 5'd13), 1'b0, 1'b0, 5'd13, 32'd0);
        add_row(enc_i(`INST_TYPE_I, 12'd9, 5'd0, 5'd13), 1'b0, 1'b0, 5'd13, 32'd0);
        add_row(enc_i(`INST_TYPE_I, 12'd9, 5'd0, 5'd13), 1'b0, 1'b0, 5'd13, 32'd0);
        add_row(enc_r(`FUNCT7_INST_A, 5'd9, 5'd12, 5'd13), 1'b1, 1'b1, 5'd13, 32'd120);
        add_row(enc_r(`FUNCT7_INST_B, 5'd6, 5'd0, 5'd14), 1'b1, 1'b1, 5'd14,
                32'd0 - 32'habcd_e000);
        add_row(enc_i(`INST_TYPE_I, r3, 5'd4, 5'd15), 1'b1, 1'b1, 5'd15, x4 + sext12(r3));
        add_row(`EBREAK_WORD, 1'b1, 1'b0, 5'd0, 32'd0);
        a_len = n_rows;
        // run B stops on an unknown word
        add_row(enc_i(`INST_TYPE_I, r4, 5'd0, 5'd1), 1'b1, 1'b1, 5'd1, sext12(r4));
        add_row(32'hffff_ffff, 1'b1, 1'b0, 5'd0, 32'd0);
        add_row(enc_i(`INST_TYPE_I, 12'd1, 5'd0, 5'd2), 1'b0, 1'b0, 5'd2, 32'd0);
        b_len = n_rows - a_len;
    endtask

    task automatic load_program(input int base, input int len);
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            if (i < len)
                imem[i] = tbl[base+i].word;
            else
                imem[i] = {16'(i), 16'hffff};   // opcode 7f, never a legal word
        end
    endtask

    task automatic wait_runs(input int n);
        int cnt;
        cnt = 0;
        while (runs_done < n && cnt < RUN_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (runs_done < n) begin
            $display("checker did not finish run %0d within %0d cycles", n - 1, RUN_LIMIT);
            checker_timeout = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n          <= 1'b0;
        checker_timeout = 1'b0;
        n_rows          = 0;
        a_len           = 0;
        b_len           = 0;
        build_table();
        load_program(0, a_len);
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        wait_runs(1);
        @(posedge clk);
        arst_n <= 1'b0;
        @(negedge clk);
        load_program(a_len, b_len);
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        wait_runs(2);
        if (checker_timeout || err_cnt != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/rvseed_pkg.sv
source/ctrl.sv
source/imm_gen.sv
source/regfile.sv
source/exec_unit.sv
source/fetch_stage.sv
source/rvseed_core.sv
bench/rvseed_props.sv
bench/rvseed_checker.sv
bench/rvseed_tb.sv

//--- run.sh
#!/bin/sh
# build the core and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rvseed_tb -f files.f -o rvseed_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/rvseed_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
